// File: source/rv_isa_pkg.sv
/*
 RV32I subset encodings: major opcodes, funct3 and funct7 codes,
 the ALU operation set and the instruction word with its R, I, S and U views
*/
package rv_isa_pkg;

   // ========================================================================
   // Major opcodes
   // ========================================================================
   localparam logic [6:0] opc_load   = 7'b0000011;
   localparam logic [6:0] opc_store  = 7'b0100011;
   localparam logic [6:0] opc_op     = 7'b0110011;
   localparam logic [6:0] opc_op_imm = 7'b0010011;
   localparam logic [6:0] opc_lui    = 7'b0110111;

   // ALU funct3, shared by OP and OP-IMM
   localparam logic [2:0] f3_add  = 3'b000;
   localparam logic [2:0] f3_sll  = 3'b001;
   localparam logic [2:0] f3_slt  = 3'b010;
   localparam logic [2:0] f3_sltu = 3'b011;
   localparam logic [2:0] f3_xor  = 3'b100;
   localparam logic [2:0] f3_sr   = 3'b101;
   localparam logic [2:0] f3_or   = 3'b110;
   localparam logic [2:0] f3_and  = 3'b111;

   // Load sizes, bit 2 set means zero extension
   localparam logic [2:0] f3_lb  = 3'b000;
   localparam logic [2:0] f3_lh  = 3'b001;
   localparam logic [2:0] f3_lw  = 3'b010;
   localparam logic [2:0] f3_lbu = 3'b100;
   localparam logic [2:0] f3_lhu = 3'b101;

   // Store sizes
   localparam logic [2:0] f3_sb = 3'b000;
   localparam logic [2:0] f3_sh = 3'b001;
   localparam logic [2:0] f3_sw = 3'b010;

   // funct7: base form and the SUB/SRA form
   localparam logic [6:0] f7_base = 7'b0000000;
   localparam logic [6:0] f7_alt  = 7'b0100000;

   typedef logic [4:0] reg_idx_t;

   typedef enum logic [3:0] {
      alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
      alu_xor, alu_srl, alu_sra, alu_or, alu_and, alu_passb
   } alu_op_e;

   // ========================================================================
   // One instruction word, four ways to read it
   // ========================================================================
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         reg_idx_t   rs2;
         reg_idx_t   rs1;
         logic [2:0] funct3;
         reg_idx_t   rd;
         logic [6:0] opcode;
      } r_fmt;
      struct packed {
         logic [11:0] imm;
         reg_idx_t    rs1;
         logic [2:0]  funct3;
         reg_idx_t    rd;
         logic [6:0]  opcode;
      } i_fmt;
      struct packed {
         logic [6:0] imm_hi;
         reg_idx_t   rs2;
         reg_idx_t   rs1;
         logic [2:0] funct3;
         logic [4:0] imm_lo;
         logic [6:0] opcode;
      } s_fmt;
      struct packed {
         logic [19:0] imm;
         reg_idx_t    rd;
         logic [6:0]  opcode;
      } u_fmt;
   } rv_inst_u;

endpackage

// File: source/rv_bus_pkg.sv
/*
 Data bus definitions: word width, AHB-Lite transfer and size codes,
 number of byte lanes
*/
package rv_bus_pkg;

   localparam int xlen = 32;

   typedef logic [xlen-1:0] word_t;

   // HTRANS, only IDLE and NONSEQ are ever issued
   localparam logic [1:0] htrans_idle   = 2'b00;
   localparam logic [1:0] htrans_nonseq = 2'b10;

   // HSIZE
   localparam logic [2:0] hsize_byte = 3'd0;
   localparam logic [2:0] hsize_half = 3'd1;
   localparam logic [2:0] hsize_word = 3'd2;

   localparam int byte_lanes = 4;

endpackage

// File: source/rv_decode.sv
/*
 Instruction decoder: register fields, I/S/U and shift-amount immediates,
 ALU operation select, memory request flags and illegal-encoding detection
*/
module rv_decode import rv_isa_pkg::*, rv_bus_pkg::*; (
   input  word_t      inst,
   input  logic       inst_valid,
   output reg_idx_t   rs1_idx,
   output reg_idx_t   rs2_idx,
   output reg_idx_t   rd_idx,
   output word_t      imm,
   output logic       use_imm,
   output alu_op_e    alu_op,
   output logic       alu_wr,
   output logic       mem_rd,
   output logic       mem_wr,
   output logic [2:0] mem_f3,
   output logic       illegal
);

   rv_inst_u   iw;
   logic [6:0] f7;
   logic [2:0] f3;
   word_t      imm_i;
   word_t      imm_s;
   word_t      imm_u;
   word_t      imm_sh;
   logic       legal;
   logic       is_alu;
   logic       is_load;
   logic       is_store;

   // Same funct3 map for OP and OP-IMM, alt picks SUB or SRA
   function automatic alu_op_e alu_from_f3(input logic [2:0] code, input logic alt);
      case (code)
         f3_add:  return alt ? alu_sub : alu_add;
         f3_sll:  return alu_sll;
         f3_slt:  return alu_slt;
         f3_sltu: return alu_sltu;
         f3_xor:  return alu_xor;
         f3_sr:   return alt ? alu_sra : alu_srl;
         f3_or:   return alu_or;
         default: return alu_and;
      endcase
   endfunction

   assign iw      = inst;
   assign f7      = iw.r_fmt.funct7;
   assign f3      = iw.r_fmt.funct3;
   assign rs1_idx = iw.r_fmt.rs1;
   assign rs2_idx = iw.r_fmt.rs2;
   assign rd_idx  = iw.r_fmt.rd;
   assign mem_f3  = f3;

   // Immediate reconstruction
   assign imm_i  = {{20{iw.i_fmt.imm[11]}}, iw.i_fmt.imm};
   assign imm_s  = {{20{iw.s_fmt.imm_hi[6]}}, iw.s_fmt.imm_hi, iw.s_fmt.imm_lo};
   assign imm_u  = {iw.u_fmt.imm, 12'b0};
   assign imm_sh = {27'b0, iw.r_fmt.rs2};

   always_comb begin
      legal    = 1'b0;
      is_alu   = 1'b0;
      is_load  = 1'b0;
      is_store = 1'b0;
      use_imm  = 1'b1;
      imm      = imm_i;
      alu_op   = alu_add;
      case (iw.r_fmt.opcode)
         opc_lui: begin
            legal  = 1'b1;
            is_alu = 1'b1;
            imm    = imm_u;
            alu_op = alu_passb;
         end
         opc_op_imm: begin
            is_alu = 1'b1;
            alu_op = alu_from_f3(f3, (f3 == f3_sr) && (f7 == f7_alt));
            if (f3 == f3_sll || f3 == f3_sr) begin
               imm   = imm_sh;
               legal = (f7 == f7_base) || (f3 == f3_sr && f7 == f7_alt);
            end else begin
               legal = 1'b1;
            end
         end
         opc_op: begin
            is_alu  = 1'b1;
            use_imm = 1'b0;
            alu_op  = alu_from_f3(f3, f7 == f7_alt);
            legal   = (f7 == f7_base) || (f7 == f7_alt && (f3 == f3_add || f3 == f3_sr));
         end
         opc_load: begin
            is_load = 1'b1;
            legal   = (f3 == f3_lb) || (f3 == f3_lh) || (f3 == f3_lw) ||
                      (f3 == f3_lbu) || (f3 == f3_lhu);
         end
         opc_store: begin
            is_store = 1'b1;
            imm      = imm_s;
            legal    = (f3 == f3_sb) || (f3 == f3_sh) || (f3 == f3_sw);
         end
         default: begin
            legal = 1'b0;
         end
      endcase
   end

   // Nothing is requested for an illegal word
   assign alu_wr  = inst_valid & legal & is_alu;
   assign mem_rd  = inst_valid & legal & is_load;
   assign mem_wr  = inst_valid & legal & is_store;
   assign illegal = inst_valid & ~legal;

endmodule

// File: source/rv_alu.sv
/*
 Integer ALU: operand B select and the RV32I register and immediate
 operations, the sum also serves as load/store address
*/
module rv_alu import rv_isa_pkg::*, rv_bus_pkg::*; (
   input  alu_op_e alu_op,
   input  word_t   rs1_val,
   input  word_t   rs2_val,
   input  word_t   imm,
   input  logic    use_imm,
   output word_t   result
);

   word_t      op_b;
   logic [4:0] shamt;
   logic       lt_signed;
   logic       lt_unsigned;

   assign op_b  = use_imm ? imm : rs2_val;
   assign shamt = op_b[4:0];

   // Comparisons for SLT and SLTU
   assign lt_signed   = $signed(rs1_val) < $signed(op_b);
   assign lt_unsigned = rs1_val < op_b;

   always_comb begin
      case (alu_op)
         alu_add: begin
            result = rs1_val + op_b;
         end
         alu_sub: begin
            result = rs1_val - op_b;
         end
         alu_sll: begin
            result = rs1_val << shamt;
         end
         alu_slt: begin
            result = {{(xlen-1){1'b0}}, lt_signed};
         end
         alu_sltu: begin
            result = {{(xlen-1){1'b0}}, lt_unsigned};
         end
         alu_xor: begin
            result = rs1_val ^ op_b;
         end
         alu_srl: begin
            result = rs1_val >> shamt;
         end
         alu_sra: begin
            result = word_t'($signed(rs1_val) >>> shamt);
         end
         alu_or: begin
            result = rs1_val | op_b;
         end
         alu_and: begin
            result = rs1_val & op_b;
         end
         alu_passb: begin
            // LUI
            result = op_b;
         end
         default: begin
            result = '0;
         end
      endcase
   end

endmodule

// File: source/rv_lsu.sv
/*
 Load/store unit: AHB-Lite address phase, store lane placement,
 data phase tracking, load extraction and the load-use interlock
*/
module rv_lsu import rv_isa_pkg::*, rv_bus_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       accept,
   input  logic       mem_rd,
   input  logic       mem_wr,
   input  logic [2:0] mem_f3,
   input  word_t      addr,
   input  word_t      store_val,
   input  reg_idx_t   rd_idx,
   input  reg_idx_t   rs1_idx,
   input  reg_idx_t   rs2_idx,
   input  word_t      hrdatad,
   input  logic       hreadyd,
   output word_t      haddrd,
   output logic [1:0] htransd,
   output logic       hwrited,
   output logic [2:0] hsized,
   output word_t      hwdatad,
   output logic       ld_wr,
   output reg_idx_t   ld_idx,
   output word_t      ld_data,
   output logic       hold
);

   logic        req;
   word_t       lane_data;
   logic        dp_valid;
   logic        dp_load;
   logic [2:0]  dp_f3;
   logic [1:0]  dp_off;
   reg_idx_t    dp_rd;
   word_t       dp_wdata;
   logic [7:0]  rd_byte;
   logic [15:0] rd_half;
   logic        wait_st;
   logic        load_use;

   // ========================================================================
   // Address phase
   // ========================================================================
   assign req     = accept & (mem_rd | mem_wr);
   assign haddrd  = addr;
   assign htransd = req ? htrans_nonseq : htrans_idle;
   assign hwrited = req & mem_wr;

   always_comb begin
      case (mem_f3[1:0])
         f3_sb[1:0]: hsized = hsize_byte;
         f3_sh[1:0]: hsized = hsize_half;
         default:    hsized = hsize_word;
      endcase
   end

   // Store bytes go to the lanes picked by the low address bits
   always_comb begin
      for (int i = 0; i < byte_lanes; i++) begin
         case (mem_f3[1:0])
            f3_sb[1:0]: lane_data[8*i +: 8] = (addr[1:0] == i[1:0]) ? store_val[7:0] : 8'h00;
            f3_sh[1:0]: lane_data[8*i +: 8] = (addr[1] == i[1]) ? store_val[8*(i%2) +: 8] : 8'h00;
            default:    lane_data[8*i +: 8] = store_val[8*i +: 8];
         endcase
      end
   end

   // ========================================================================
   // Data phase state, advances only when the bus is ready
   // ========================================================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dp_valid <= 1'b0;
         dp_load  <= 1'b0;
      end else if (hreadyd) begin
         dp_valid <= req;
         dp_load  <= req & mem_rd;
      end
   end

   always_ff @(posedge clk) begin
      if (hreadyd && req) begin
         dp_f3    <= mem_f3;
         dp_off   <= addr[1:0];
         dp_rd    <= rd_idx;
         dp_wdata <= lane_data;
      end
   end

   assign hwdatad = dp_wdata;

   // Load extraction
   assign rd_byte = hrdatad[{dp_off, 3'b000} +: 8];
   assign rd_half = hrdatad[{dp_off[1], 4'b0000} +: 16];

   always_comb begin
      case (dp_f3)
         f3_lb:   ld_data = {{24{rd_byte[7]}}, rd_byte};
         f3_lbu:  ld_data = {24'b0, rd_byte};
         f3_lh:   ld_data = {{16{rd_half[15]}}, rd_half};
         f3_lhu:  ld_data = {16'b0, rd_half};
         default: ld_data = hrdatad;
      endcase
   end

   assign ld_wr  = dp_load & hreadyd;
   assign ld_idx = dp_rd;

   // Stall on wait states, or while a pending load feeds the current word
   assign wait_st  = dp_valid & ~hreadyd;
   assign load_use = dp_load & (dp_rd != '0) & ((dp_rd == rs1_idx) | (dp_rd == rs2_idx));
   assign hold     = wait_st | load_use;

endmodule

// File: source/rv_regfile.sv
/*
 Register file: x1..x31 with two combinational read ports,
 write port A for ALU results and write port B for load data
*/
module rv_regfile import rv_isa_pkg::*, rv_bus_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  reg_idx_t ra_idx,
   input  reg_idx_t rb_idx,
   input  logic     wa_en,
   input  reg_idx_t wa_idx,
   input  word_t    wa_data,
   input  logic     wb_en,
   input  reg_idx_t wb_idx,
   input  word_t    wb_data,
   output word_t    ra_data,
   output word_t    rb_data
);

   // x0 has no storage
   word_t regs [1:31];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (wb_en && wb_idx != '0) begin
            regs[wb_idx] <= wb_data;
         end
         // Port A holds the younger result, so it is assigned last
         if (wa_en && wa_idx != '0) begin
            regs[wa_idx] <= wa_data;
         end
      end
   end

   assign ra_data = (ra_idx == '0) ? '0 : regs[ra_idx];
   assign rb_data = (rb_idx == '0) ? '0 : regs[rb_idx];

endmodule

// File: source/rv_core_slice.sv
/*
 Execute and data-memory slice of an RV32I core:
 decoder, ALU, load/store unit and register file
*/
module rv_core_slice import rv_isa_pkg::*, rv_bus_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  word_t      inst,
   input  logic       inst_valid,
   input  word_t      hrdatad,
   input  logic       hreadyd,
   output logic       busy,
   output logic       illegal,
   output word_t      haddrd,
   output logic [1:0] htransd,
   output logic       hwrited,
   output logic [2:0] hsized,
   output word_t      hwdatad
);

   logic       accept;
   logic       hold;
   reg_idx_t   rs1_idx;
   reg_idx_t   rs2_idx;
   reg_idx_t   rd_idx;
   word_t      imm;
   logic       use_imm;
   alu_op_e    alu_op;
   logic       alu_wr;
   logic       mem_rd;
   logic       mem_wr;
   logic [2:0] mem_f3;
   word_t      rs1_val;
   word_t      rs2_val;
   word_t      alu_res;
   logic       ld_wr;
   reg_idx_t   ld_idx;
   word_t      ld_data;

   assign accept = inst_valid & ~hold;
   assign busy   = hold;

   // Decoder sees only accepted words
   rv_decode u_rv_decode (
      .inst       (inst),
      .inst_valid (accept),
      .rs1_idx    (rs1_idx),
      .rs2_idx    (rs2_idx),
      .rd_idx     (rd_idx),
      .imm        (imm),
      .use_imm    (use_imm),
      .alu_op     (alu_op),
      .alu_wr     (alu_wr),
      .mem_rd     (mem_rd),
      .mem_wr     (mem_wr),
      .mem_f3     (mem_f3),
      .illegal    (illegal)
   );

   rv_alu u_rv_alu (
      .alu_op  (alu_op),
      .rs1_val (rs1_val),
      .rs2_val (rs2_val),
      .imm     (imm),
      .use_imm (use_imm),
      .result  (alu_res)
   );

   rv_lsu u_rv_lsu (
      .clk       (clk),
      .rst_n     (rst_n),
      .accept    (accept),
      .mem_rd    (mem_rd),
      .mem_wr    (mem_wr),
      .mem_f3    (mem_f3),
      .addr      (alu_res),
      .store_val (rs2_val),
      .rd_idx    (rd_idx),
      .rs1_idx   (rs1_idx),
      .rs2_idx   (rs2_idx),
      .hrdatad   (hrdatad),
      .hreadyd   (hreadyd),
      .haddrd    (haddrd),
      .htransd   (htransd),
      .hwrited   (hwrited),
      .hsized    (hsized),
      .hwdatad   (hwdatad),
      .ld_wr     (ld_wr),
      .ld_idx    (ld_idx),
      .ld_data   (ld_data),
      .hold      (hold)
   );

   // Port A takes ALU results, port B the late load data
   rv_regfile u_rv_regfile (
      .clk     (clk),
      .rst_n   (rst_n),
      .ra_idx  (rs1_idx),
      .rb_idx  (rs2_idx),
      .wa_en   (alu_wr),
      .wa_idx  (rd_idx),
      .wa_data (alu_res),
      .wb_en   (ld_wr),
      .wb_idx  (ld_idx),
      .wb_data (ld_data),
      .ra_data (rs1_val),
      .rb_data (rs2_val)
   );

endmodule

// File: tb/tb_programs.svh
/*
 Stimulus for the core slice testbench with the instruction encoders,
 the table entry type, the program table with expected stores
 and the initial memory image
*/

typedef struct {
   word_t      inst;
   logic       store;
   logic       ill;
   word_t      addr;
   logic [2:0] size;
   word_t      data;
} entry_t;

entry_t prog[$];

// Image words 0 and 1 are the load targets
word_t image [16] = '{
   32'h80FF_7F01, 32'hC3A5_5A3C, 32'h0123_4567, 32'h89AB_CDEF,
   32'hDEAD_BEEF, 32'h7654_3210, 32'hFEDC_BA98, 32'h0F0F_F0F0,
   32'h5555_AAAA, 32'h1357_9BDF, 32'h2468_ACE0, 32'hCAFE_F00D,
   32'h0000_FFFF, 32'hFFFF_0000, 32'h3C3C_C3C3, 32'h8000_0001
};

// ============================================================================
// Encoders built on the instruction word views
// ============================================================================
function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                logic [2:0] f3, reg_idx_t rd, logic [6:0] opc);
   rv_inst_u w;
   w.r_fmt.funct7 = f7;
   w.r_fmt.rs2    = rs2;
   w.r_fmt.rs1    = rs1;
   w.r_fmt.funct3 = f3;
   w.r_fmt.rd     = rd;
   w.r_fmt.opcode = opc;
   return w;
endfunction

function automatic word_t enc_i(logic [6:0] opc, logic [2:0] f3, reg_idx_t rd,
                                reg_idx_t rs1, logic [11:0] imm);
   rv_inst_u w;
   w.i_fmt.imm    = imm;
   w.i_fmt.rs1    = rs1;
   w.i_fmt.funct3 = f3;
   w.i_fmt.rd     = rd;
   w.i_fmt.opcode = opc;
   return w;
endfunction

function automatic word_t enc_s(logic [2:0] f3, reg_idx_t rs2, reg_idx_t rs1,
                                logic [11:0] imm);
   rv_inst_u w;
   w.s_fmt.imm_hi = imm[11:5];
   w.s_fmt.rs2    = rs2;
   w.s_fmt.rs1    = rs1;
   w.s_fmt.funct3 = f3;
   w.s_fmt.imm_lo = imm[4:0];
   w.s_fmt.opcode = opc_store;
   return w;
endfunction

function automatic word_t enc_u(reg_idx_t rd, logic [19:0] imm);
   rv_inst_u w;
   w.u_fmt.imm    = imm;
   w.u_fmt.rd     = rd;
   w.u_fmt.opcode = opc_lui;
   return w;
endfunction

function automatic word_t opi(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
   return enc_i(opc_op_imm, f3, rd, rs1, imm);
endfunction

function automatic word_t op(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
                             reg_idx_t rs2);
   return enc_r(f7, rs2, rs1, f3, rd, opc_op);
endfunction

function automatic word_t ld(logic [2:0] f3, reg_idx_t rd, logic [11:0] addr);
   return enc_i(opc_load, f3, rd, 5'd0, addr);
endfunction

// ============================================================================
// Table building
// ============================================================================
task automatic add_word(input word_t w, input logic ill);
   prog.push_back('{inst: w, store: 1'b0, ill: ill, addr: 32'h0, size: 3'd0, data: 32'h0});
endtask

task automatic add_store(input word_t w, input word_t addr, input logic [2:0] size,
                         input word_t data);
   prog.push_back('{inst: w, store: 1'b1, ill: 1'b0, addr: addr, size: size, data: data});
endtask

// SW to the fixed result address 0x100
task automatic store_reg(input reg_idx_t rs, input word_t expect_val);
   add_store(enc_s(f3_sw, rs, 5'd0, 12'h100), 32'h100, hsize_word, expect_val);
endtask

task automatic exec_store(input word_t w, input reg_idx_t rd, input word_t expect_val);
   add_word(w, 1'b0);
   store_reg(rd, expect_val);
endtask

task automatic build_program();
   // Arithmetic with x1 as min int and x2 as -5
   exec_store(enc_u(5'd1, 20'h80000), 5'd1, 32'h8000_0000);
   exec_store(opi(f3_add, 5'd2, 5'd0, 12'hFFB), 5'd2, 32'hFFFF_FFFB);
   exec_store(opi(f3_slt, 5'd3, 5'd2, 12'hFFC), 5'd3, 32'h1);
   exec_store(opi(f3_sltu, 5'd4, 5'd2, 12'h005), 5'd4, 32'h0);
   exec_store(opi(f3_xor, 5'd5, 5'd2, 12'h0F0), 5'd5, 32'hFFFF_FF0B);
   exec_store(opi(f3_or, 5'd6, 5'd0, 12'h555), 5'd6, 32'h0000_0555);
   exec_store(opi(f3_and, 5'd7, 5'd2, 12'h7FF), 5'd7, 32'h0000_07FB);
   exec_store(opi(f3_sll, 5'd8, 5'd2, 12'h01F), 5'd8, 32'h8000_0000);
   exec_store(opi(f3_sll, 5'd9, 5'd2, 12'h000), 5'd9, 32'hFFFF_FFFB);
   exec_store(opi(f3_sr, 5'd10, 5'd1, 12'h01F), 5'd10, 32'h1);
   exec_store(opi(f3_sr, 5'd11, 5'd1, 12'h41F), 5'd11, 32'hFFFF_FFFF);
   exec_store(opi(f3_sr, 5'd12, 5'd2, 12'h400), 5'd12, 32'hFFFF_FFFB);
   exec_store(opi(f3_sr, 5'd13, 5'd2, 12'h004), 5'd13, 32'h0FFF_FFFF);
   exec_store(op(f7_base, f3_add, 5'd14, 5'd1, 5'd2), 5'd14, 32'h7FFF_FFFB);
   exec_store(op(f7_alt, f3_add, 5'd15, 5'd0, 5'd2), 5'd15, 32'h5);
   exec_store(op(f7_base, f3_sll, 5'd16, 5'd6, 5'd10), 5'd16, 32'h0000_0AAA);
   exec_store(op(f7_base, f3_slt, 5'd17, 5'd1, 5'd2), 5'd17, 32'h1);
   exec_store(op(f7_base, f3_sltu, 5'd18, 5'd1, 5'd2), 5'd18, 32'h1);
   exec_store(op(f7_base, f3_xor, 5'd19, 5'd6, 5'd7), 5'd19, 32'h0000_02AE);
   exec_store(op(f7_base, f3_sr, 5'd20, 5'd1, 5'd10), 5'd20, 32'h4000_0000);
   exec_store(op(f7_alt, f3_sr, 5'd21, 5'd1, 5'd10), 5'd21, 32'hC000_0000);
   exec_store(op(f7_base, f3_or, 5'd22, 5'd6, 5'd7), 5'd22, 32'h0000_07FF);
   exec_store(op(f7_base, f3_and, 5'd23, 5'd6, 5'd7), 5'd23, 32'h0000_0551);
   // Loads each used at once by the following SW
   exec_store(ld(f3_lb, 5'd25, 12'h000), 5'd25, 32'h0000_0001);
   exec_store(ld(f3_lb, 5'd25, 12'h001), 5'd25, 32'h0000_007F);
   exec_store(ld(f3_lb, 5'd25, 12'h002), 5'd25, 32'hFFFF_FFFF);
   exec_store(ld(f3_lb, 5'd25, 12'h003), 5'd25, 32'hFFFF_FF80);
   exec_store(ld(f3_lbu, 5'd25, 12'h003), 5'd25, 32'h0000_0080);
   exec_store(ld(f3_lbu, 5'd25, 12'h002), 5'd25, 32'h0000_00FF);
   exec_store(ld(f3_lh, 5'd25, 12'h000), 5'd25, 32'h0000_7F01);
   exec_store(ld(f3_lh, 5'd25, 12'h002), 5'd25, 32'hFFFF_80FF);
   exec_store(ld(f3_lhu, 5'd25, 12'h002), 5'd25, 32'h0000_80FF);
   exec_store(ld(f3_lhu, 5'd25, 12'h004), 5'd25, 32'h0000_5A3C);
   exec_store(ld(f3_lbu, 5'd25, 12'h005), 5'd25, 32'h0000_005A);
   exec_store(ld(f3_lb, 5'd25, 12'h006), 5'd25, 32'hFFFF_FFA5);
   exec_store(ld(f3_lw, 5'd25, 12'h004), 5'd25, 32'hC3A5_5A3C);
   // Byte and half stores of 0x12345678
   add_word(enc_u(5'd26, 20'h12345), 1'b0);
   exec_store(opi(f3_add, 5'd26, 5'd26, 12'h678), 5'd26, 32'h1234_5678);
   add_store(enc_s(f3_sb, 5'd26, 5'd0, 12'h108), 32'h108, hsize_byte, 32'h0000_0078);
   add_store(enc_s(f3_sb, 5'd26, 5'd0, 12'h109), 32'h109, hsize_byte, 32'h0000_7800);
   add_store(enc_s(f3_sb, 5'd26, 5'd0, 12'h10A), 32'h10A, hsize_byte, 32'h0078_0000);
   add_store(enc_s(f3_sb, 5'd26, 5'd0, 12'h10B), 32'h10B, hsize_byte, 32'h7800_0000);
   add_store(enc_s(f3_sh, 5'd26, 5'd0, 12'h10C), 32'h10C, hsize_half, 32'h0000_5678);
   add_store(enc_s(f3_sh, 5'd26, 5'd0, 12'h10E), 32'h10E, hsize_half, 32'h5678_0000);
   exec_store(ld(f3_lw, 5'd27, 12'h108), 5'd27, 32'h7878_7878);
   exec_store(ld(f3_lw, 5'd27, 12'h10C), 5'd27, 32'h5678_5678);
   // Both write ports hit x28 at one edge and the ADDI is younger
   add_word(ld(f3_lw, 5'd28, 12'h004), 1'b0);
   exec_store(opi(f3_add, 5'd28, 5'd0, 12'h007), 5'd28, 32'h7);
   add_word(ld(f3_lw, 5'd28, 12'h000), 1'b0);
   exec_store(opi(f3_add, 5'd29, 5'd28, 12'h001), 5'd29, 32'h80FF_7F02);
   // Illegal words must leave x29 alone
   add_word(opi(f3_add, 5'd29, 5'd0, 12'h123), 1'b0);
   add_word(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd29, 7'b1111111), 1'b1);
   add_word(op(7'h01, f3_add, 5'd29, 5'd1, 5'd2), 1'b1);
   add_word(enc_i(opc_load, 3'b011, 5'd29, 5'd0, 12'h004), 1'b1);
   add_word(opi(f3_sll, 5'd29, 5'd1, 12'h401), 1'b1);
   store_reg(5'd29, 32'h123);
   // x0 stays zero
   exec_store(opi(f3_add, 5'd0, 5'd0, 12'h037), 5'd0, 32'h0);
   exec_store(ld(f3_lw, 5'd0, 12'h000), 5'd0, 32'h0);
endtask

// File: tb/tb_core_slice.sv
/*
 Testbench for the core slice with clock and reset, the table-driven
 instruction stream, an AHB-Lite data memory with random wait states
 and the store checks
*/
module tb_core_slice import rv_isa_pkg::*, rv_bus_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   logic       clk;
   logic       rst_n;
   word_t      inst;
   logic       inst_valid;
   word_t      hrdatad;
   logic       hreadyd;
   logic       busy;
   logic       illegal;
   word_t      haddrd;
   logic [1:0] htransd;
   logic       hwrited;
   logic [2:0] hsized;
   word_t      hwdatad;

   `include "tb_programs.svh"

   word_t       mem [0:127];
   entry_t      exp_q[$];
   int          cycles = 0;
   int          cycle_limit = 1000;
   logic [31:0] lfsr = 32'h5781_2465;

   rv_core_slice u_rv_core_slice (
      .clk        (clk),
      .rst_n      (rst_n),
      .inst       (inst),
      .inst_valid (inst_valid),
      .hrdatad    (hrdatad),
      .hreadyd    (hreadyd),
      .busy       (busy),
      .illegal    (illegal),
      .haddrd     (haddrd),
      .htransd    (htransd),
      .hwrited    (hwrited),
      .hsized     (hsized),
      .hwdatad    (hwdatad)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("TEST FAIL");
      $fatal(1, "run stopped");
   endtask

   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // Byte enable for one lane from size and offset
   function automatic logic lane_on(logic [2:0] size, logic [1:0] off, int lane);
      case (size)
         hsize_byte: return off == lane[1:0];
         hsize_half: return off[1] == lane[1];
         default:    return 1'b1;
      endcase
   endfunction

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > cycle_limit) begin
         fail_run("timeout, the run did not finish in time");
      end
   end

   // ========================================================================
   // Data memory with one data phase at a time
   // ========================================================================
   always @(posedge clk) begin : mem_model
      entry_t      e;
      logic [1:0]  r;
      logic [1:0]  waits;
      logic        dp_act;
      logic        dp_wr;
      word_t       dp_addr;
      logic [2:0]  dp_size;
      if (rst_n) begin
         if (busy) begin
            assert (htransd == htrans_idle) else fail_run("transfer issued while busy");
         end
         if (dp_act && hreadyd) begin
            if (dp_wr) begin
               assert (exp_q.size() != 0) else fail_run("store seen with none expected");
               e = exp_q.pop_front();
               assert (dp_addr == e.addr) else
                  fail_run($sformatf("mismatch haddrd: got %h expected %h", dp_addr, e.addr));
               assert (dp_size == e.size) else
                  fail_run($sformatf("mismatch hsized: got %h expected %h", dp_size, e.size));
               assert (hwdatad == e.data) else
                  fail_run($sformatf("mismatch hwdatad: got %h expected %h", hwdatad, e.data));
               for (int b = 0; b < byte_lanes; b++) begin
                  if (lane_on(dp_size, dp_addr[1:0], b)) begin
                     mem[dp_addr[8:2]][8*b +: 8] = hwdatad[8*b +: 8];
                  end
               end
            end
            dp_act = 1'b0;
         end
         if (htransd == htrans_nonseq && hreadyd) begin
            dp_act  = 1'b1;
            dp_wr   = hwrited;
            dp_addr = haddrd;
            dp_size = hsized;
            lfsr    = lfsr_next(lfsr);
            r[0]    = lfsr[0];
            lfsr    = lfsr_next(lfsr);
            r[1]    = lfsr[0];
            waits   = (r == 2'd3) ? 2'd0 : r;
         end else if (dp_act && waits != 2'd0) begin
            waits = waits - 2'd1;
         end
         hreadyd <= !(dp_act && waits != 2'd0);
         hrdatad <= dp_act ? mem[dp_addr[8:2]] : 32'h0;
      end else begin
         dp_act = 1'b0;
         waits  = 2'd0;
      end
   end

   // Present one entry and wait for its accept cycle
   task automatic apply_entry(input entry_t e);
      rv_inst_u   w;
      logic       is_mem;
      logic [1:0] exp_trans;
      w = e.inst;
      is_mem = !e.ill && (w.r_fmt.opcode == opc_load || w.r_fmt.opcode == opc_store);
      exp_trans = is_mem ? htrans_nonseq : htrans_idle;
      inst       <= e.inst;
      inst_valid <= 1'b1;
      @(posedge clk);
      while (busy) begin
         @(posedge clk);
      end
      assert (illegal == e.ill) else
         fail_run($sformatf("mismatch illegal: got %h expected %h", illegal, e.ill));
      assert (htransd == exp_trans) else
         fail_run($sformatf("mismatch htransd: got %h expected %h", htransd, exp_trans));
      if (is_mem) begin
         assert (hwrited == e.store) else
            fail_run($sformatf("mismatch hwrited: got %h expected %h", hwrited, e.store));
      end
      if (e.store) begin
         exp_q.push_back(e);
      end
   endtask

   // ========================================================================
   // Main sequence
   // ========================================================================
   initial begin
      rst_n      = 1'b0;
      inst       = '0;
      inst_valid = 1'b0;
      hrdatad    = '0;
      hreadyd    = 1'b1;
      for (int i = 0; i < 128; i++) begin
         mem[i] = (i * 4) * 32'h0100_0193 ^ 32'h5BD1_E995;
      end
      for (int i = 0; i < 16; i++) begin
         mem[i] = image[i];
      end
      build_program();
      cycle_limit = 16 + 4 * prog.size() + 100;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      assert (!busy && !illegal && !hwrited && htransd == htrans_idle) else
         fail_run("bus or status outputs not idle after reset");
      foreach (prog[i]) begin
         apply_entry(prog[i]);
      end
      inst_valid <= 1'b0;
      inst       <= '0;
      while (exp_q.size() != 0) begin
         @(posedge clk);
      end
      repeat (2) @(posedge clk);
      $display("TEST PASS");
      $finish;
   end

endmodule

// File: src.f
+incdir+tb
source/rv_isa_pkg.sv
source/rv_bus_pkg.sv
source/rv_decode.sv
source/rv_alu.sv
source/rv_lsu.sv
source/rv_regfile.sv
source/rv_core_slice.sv
tb/tb_core_slice.sv

// File: run.sh
#!/bin/sh
# Build with Verilator and run the core slice testbench
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module tb_core_slice \
   -Mdir obj_dir -o sim

# The simulator exits nonzero on a failure, the log decides
./obj_dir/sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
   echo "simulation failed"
   exit 1
fi
grep -q "TEST PASS" sim.log
echo "simulation passed"
